//--- project.f
+incdir+bench
source/issue_pkg.sv
source/predecode.sv
source/issue_queue.sv
source/pair_select.sv
source/issue_stage.sv
bench/issue_checker.sv
bench/issue_bench.sv

//--- run.sh
#!/bin/sh
# build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module issue_bench \
  -o issue_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/issue_sim > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
fi

if grep -q "All checks passed" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL, see sim.log"
  exit 1
fi

//--- bench/issue_model.svh
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

logic [31:0] lcg_state = 32'd43318;
issue_pkg::instruction_type model_q[$];

function automatic logic [31:0] next_random();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state >> 8; // low bits of an lcg repeat quickly
endfunction

function automatic issue_pkg::instruction_type model_decode(logic [31:0] w, logic v);
  issue_pkg::instruction_type d;
  logic known;
  d = issue_pkg::init_instruction;
  known = 1'b1;
  d.word = w;
  d.waddr = w[11:7];
  d.raddr1 = w[19:15];
  d.raddr2 = w[24:20];
  case (w[6:0])
    7'h37: begin d.op.lui = 1'b1; d.op.wren = 1'b1; end
    7'h17: begin d.op.auipc = 1'b1; d.op.wren = 1'b1; end
    7'h6f: begin d.op.jal = 1'b1; d.op.wren = 1'b1; end
    7'h67: begin d.op.jalr = 1'b1; d.op.wren = 1'b1; d.op.rden1 = 1'b1; end
    7'h63: begin d.op.branch = 1'b1; d.op.rden1 = 1'b1; d.op.rden2 = 1'b1; end
    7'h03: begin d.op.load = 1'b1; d.op.wren = 1'b1; d.op.rden1 = 1'b1; end
    7'h23: begin d.op.store = 1'b1; d.op.rden1 = 1'b1; d.op.rden2 = 1'b1; end
    7'h13: begin d.op.alu = 1'b1; d.op.wren = 1'b1; d.op.rden1 = 1'b1; end
    7'h33: begin
      if (w[31:25] == 7'd1 && w[14:12] >= 3'd4) d.op.division = 1'b1;
      else if (w[31:25] == 7'd1) d.op.mult = 1'b1;
      else d.op.alu = 1'b1;
      d.op.wren = 1'b1;
      d.op.rden1 = 1'b1;
      d.op.rden2 = 1'b1;
    end
    7'h07: begin d.op.fload = 1'b1; d.op.rden1 = 1'b1; end
    7'h27: begin d.op.fstore = 1'b1; d.op.rden1 = 1'b1; end
    7'h53: d.op.fpu = 1'b1;
    7'h0f: d.op.fence = 1'b1;
    7'h73: begin
      if (w[14:12] == 3'd0) begin
        if (w[31:20] == 12'h000) d.op.ecall = 1'b1;
        else if (w[31:20] == 12'h001) d.op.ebreak = 1'b1;
        else if (w[31:20] == 12'h302) d.op.mret = 1'b1;
        else if (w[31:20] == 12'h105) d.op.wfi = 1'b1;
        else known = 1'b0;
      end else if (w[14:12] == 3'd4) begin
        known = 1'b0;
      end else begin
        d.op.csreg = 1'b1;
        d.op.wren = 1'b1;
        d.op.rden1 = (w[14:12] < 3'd4);
      end
    end
    default: known = 1'b0;
  endcase
  if (w[11:7] == 5'd0) d.op.wren = 1'b0;
  d.op.valid = v && known;
  return d;
endfunction

function automatic logic model_basic(issue_pkg::op_type o);
  return o.alu || o.lui || o.auipc || o.jal || o.jalr || o.branch;
endfunction

// one cycle of queue and pairing, returns the expected lanes
function automatic issue_pkg::issue_pair_type model_step(issue_pkg::fetch_pair_type f,
    logic clr, logic hld, output logic stall_out);
  issue_pkg::instruction_type d;
  issue_pkg::instruction_type h0;
  issue_pkg::instruction_type h1;
  issue_pkg::issue_pair_type r;
  logic b0;
  logic b1;
  logic dep;
  int n;
  if (clr) begin
    model_q.delete();
  end else begin
    d = model_decode(f.word0, f.valid0);
    if (d.op.valid) model_q.push_back(d);
    d = model_decode(f.word1, f.valid1);
    if (d.op.valid) model_q.push_back(d);
  end
  h0 = (model_q.size() > 0) ? model_q[0] : issue_pkg::init_instruction;
  h1 = (model_q.size() > 1) ? model_q[1] : issue_pkg::init_instruction;
  b0 = model_basic(h0.op);
  b1 = model_basic(h1.op);
  dep = h0.op.wren && ((h1.op.rden1 && h1.raddr1 == h0.waddr) ||
    (h1.op.rden2 && h1.raddr2 == h0.waddr));
  n = ((b0 || b1) && !dep) ? 2 : 1; // every valid entry is basic or complex
  if (hld) n = 0;
  if (n > model_q.size()) n = model_q.size();
  r.swap = (n == 2) && b0 && !b1;
  r.instr0 = (n > 0) ? (r.swap ? h1 : h0) : issue_pkg::init_instruction;
  r.instr1 = (n > 1) ? (r.swap ? h0 : h1) : issue_pkg::init_instruction;
  repeat (n) void'(model_q.pop_front());
  stall_out = model_q.size() > issue_pkg::stall_level;
  return r;
endfunction

`endif

//--- bench/issue_bench.sv
`timescale 1ns/1ps

module issue_bench;

  localparam int reset_cycles = 16;
  localparam int directed_cycles = 60;
  localparam int random_cycles = 2000;
  localparam int timeout_ns = (reset_cycles + directed_cycles + random_cycles) * 10 + 500;

  logic clock = 1'b0;
  logic reset = 1'b0;
  logic clear = 1'b0;
  logic hold = 1'b0;
  issue_pkg::fetch_pair_type fetch = '0;
  issue_pkg::issue_pair_type issue;
  logic stall;

  issue_pkg::issue_pair_type exp_issue;
  logic exp_stall;
  logic check_enable = 1'b0;

  `include "issue_model.svh"

  issue_stage issue_stage_inst (
    .clock(clock),
    .reset(reset),
    .clear(clear),
    .hold(hold),
    .fetch(fetch),
    .issue(issue),
    .stall(stall)
  );

  always #5 clock = ~clock;

  task automatic report_failure(string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic compare_issue(issue_pkg::issue_pair_type got, issue_pkg::issue_pair_type exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error issue: got %h expected %h", got, exp));
    end
  endtask

  task automatic compare_stall(logic got, logic exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error stall: got %h expected %h", got, exp));
    end
  endtask

  function automatic logic [31:0] template_word(int k);
    case (k)
      0: return 32'h00000013; // addi
      1: return 32'h00000033; // add
      2: return 32'h00000037;
      3: return 32'h00000063;
      4: return 32'h00002003; // lw
      5: return 32'h00002023;
      6: return 32'h02000033; // mul
      7: return 32'h02004033; // div
      8: return 32'h0000006f;
      9: return 32'h00000067;
      10: return 32'h00000017;
      11: return 32'h00002007;
      12: return 32'h00002027;
      13: return 32'h00000053;
      14: return 32'h0ff0000f; // fence
      15: return 32'h00000073;
      16: return 32'h00100073;
      17: return 32'h30200073;
      18: return 32'h10500073; // wfi
      19: return 32'h30001073;
      default: return 32'h30005073; // csrrwi
    endcase
  endfunction

  function automatic logic [31:0] make_word(int k, logic [4:0] rd, logic [4:0] rs1,
      logic [4:0] rs2);
    logic [31:0] t;
    t = template_word(k);
    if (k < 14 || k > 18) begin
      t[11:7] = rd;
      t[19:15] = rs1;
      t[24:20] = rs2;
    end
    return t;
  endfunction

  function automatic logic [31:0] random_word();
    int k;
    k = int'(next_random() % 32'd21);
    return make_word(k, 5'(next_random() % 4), 5'(next_random() % 4), 5'(next_random() % 4));
  endfunction

  task automatic drive_cycle(logic [31:0] w0, logic v0, logic [31:0] w1, logic v1,
      logic clr, logic hld);
    @(posedge clock);
    #1;
    if (model_q.size() > issue_pkg::stall_level) begin
      v0 = 1'b0; // fetch waits while stall is up
      v1 = 1'b0;
    end
    fetch = '{word0: w0, word1: w1, valid0: v0, valid1: v1};
    clear = clr;
    hold = hld;
    exp_issue = model_step(fetch, clr, hld, exp_stall);
    check_enable = 1'b1;
  endtask

  always @(negedge clock) begin
    if (check_enable) begin
      compare_issue(issue, exp_issue);
      compare_stall(stall, exp_stall);
    end
  end

  initial begin
    #(timeout_ns);
    report_failure("watchdog expired before the tests finished");
  end

  initial begin
    logic v0;
    repeat (reset_cycles) @(posedge clock);
    #1 reset = 1'b1;
    // independent basic pair
    drive_cycle(make_word(0, 1, 2, 0), 1, make_word(0, 3, 4, 0), 1, 0, 0);
    // dependent pair issues one per cycle
    drive_cycle(make_word(0, 1, 2, 0), 1, make_word(1, 5, 1, 3), 1, 0, 0);
    drive_cycle(0, 0, 0, 0, 0, 0);
    // two complex, then basic with complex
    drive_cycle(make_word(4, 6, 2, 0), 1, make_word(6, 7, 3, 2), 1, 0, 0);
    drive_cycle(0, 0, 0, 0, 0, 0);
    drive_cycle(make_word(0, 8, 2, 0), 1, make_word(4, 9, 3, 0), 1, 0, 0);
    drive_cycle(0, 0, 0, 0, 0, 0);
    // fill under hold
    repeat (6) drive_cycle(random_word(), 1, random_word(), 1, 0, 1);
    repeat (8) drive_cycle(0, 0, 0, 0, 0, 0);
    // clear a filled queue
    repeat (3) drive_cycle(random_word(), 1, random_word(), 1, 0, 1);
    drive_cycle(random_word(), 1, random_word(), 1, 1, 1);
    drive_cycle(make_word(0, 2, 3, 0), 1, make_word(2, 4, 0, 0), 1, 0, 0);
    drive_cycle(0, 0, 0, 0, 0, 0);
    repeat (random_cycles) begin
      v0 = (next_random() % 4) != 0;
      drive_cycle(random_word(), v0, random_word(), v0 && (next_random() % 2 == 0),
        (next_random() % 50) == 0, (next_random() % 4) == 0);
    end
    @(posedge clock);
    #1;
    $display("All checks passed");
    $finish;
  end

endmodule

//--- bench/issue_checker.sv
`timescale 1ns/1ps

module issue_checker (
  input logic clock,
  input logic reset,
  input issue_pkg::issue_pair_type issue,
  input logic stall
);

  // queue is empty right after reset
  assert property (@(posedge clock) !reset |=> !stall)
    else $error("stall high in the cycle after reset");

  assert property (@(posedge clock) disable iff (!reset)
    issue.swap |-> (issue.instr0.op.valid && issue.instr1.op.valid))
    else $error("swap set without two valid lanes");

  assert property (@(posedge clock) disable iff (!reset)
    issue.instr1.op.valid |-> issue.instr0.op.valid)
    else $error("lane 1 valid while lane 0 empty");

endmodule

bind issue_stage issue_checker issue_checker_inst (
  .clock(clock),
  .reset(reset),
  .issue(issue),
  .stall(stall)
);

//--- source/issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
  input logic clock,
  input logic reset,
  input logic clear,
  input logic hold,
  input issue_pkg::fetch_pair_type fetch,
  output issue_pkg::issue_pair_type issue,
  output logic stall
);

  issue_pkg::instruction_type decoded0;
  issue_pkg::instruction_type decoded1;
  issue_pkg::instruction_type head0;
  issue_pkg::instruction_type head1;
  logic [1:0] issue_count;

  predecode predecode0_inst (
    .word(fetch.word0),
    .valid(fetch.valid0),
    .instr(decoded0)
  );

  predecode predecode1_inst (
    .word(fetch.word1),
    .valid(fetch.valid1), // older word is word0
    .instr(decoded1)
  );

  issue_queue issue_queue_inst (
    .clock(clock),
    .reset(reset),
    .clear(clear),
    .in0(decoded0),
    .in1(decoded1),
    .issue_count(issue_count),
    .head0(head0),
    .head1(head1),
    .stall(stall)
  );

  pair_select pair_select_inst (
    .head0(head0),
    .head1(head1),
    .hold(hold),
    .issue_count(issue_count),
    .issue(issue)
  );

endmodule

//--- source/pair_select.sv
`timescale 1ns/1ps

module pair_select (
  input issue_pkg::instruction_type head0,
  input issue_pkg::instruction_type head1,
  input logic hold,
  output logic [1:0] issue_count,
  output issue_pkg::issue_pair_type issue
);

  function automatic logic is_basic(input issue_pkg::op_type op);
    return op.alu | op.lui | op.auipc | op.jal | op.jalr | op.branch;
  endfunction

  function automatic logic is_complex(input issue_pkg::op_type op);
    logic memory;
    logic arith;
    logic system;
    memory = op.load | op.store | op.fload | op.fstore;
    arith = op.mult | op.division | op.fpu;
    system = op.csreg | op.fence | op.ecall | op.ebreak | op.mret | op.wfi;
    return memory | arith | system;
  endfunction

  logic basic0;
  logic basic1;
  logic complex0;
  logic complex1;
  logic pairable;
  logic depend;
  logic [1:0] valid_count;
  logic [1:0] count;
  logic swap;

  assign basic0 = is_basic(head0.op);
  assign basic1 = is_basic(head1.op);
  assign complex0 = is_complex(head0.op);
  assign complex1 = is_complex(head1.op);

  // two complex never pair
  assign pairable = (basic0 & basic1) | (basic0 & complex1) | (complex0 & basic1);

  // younger reads what older writes
  assign depend = head0.op.wren &
    ((head1.op.rden1 & (head1.raddr1 == head0.waddr)) |
     (head1.op.rden2 & (head1.raddr2 == head0.waddr)));

  assign valid_count = {1'b0, head0.op.valid} + {1'b0, head1.op.valid};

  always_comb begin
    count = 2'd1;
    if (pairable && !depend) begin
      count = 2'd2;
    end
    if (hold) begin
      count = 2'd0;
    end
    if (count > valid_count) begin
      count = valid_count; // never more than the queue shows
    end
  end

  assign swap = (count == 2'd2) & basic0 & complex1;
  assign issue_count = count;

  always_comb begin
    issue.instr0 = issue_pkg::init_instruction;
    issue.instr1 = issue_pkg::init_instruction;
    if (count > 2'd0) begin
      issue.instr0 = swap ? head1 : head0; // complex always in lane 0
    end
    if (count > 2'd1) begin
      issue.instr1 = swap ? head0 : head1;
    end
    issue.swap = swap;
  end

endmodule

//--- source/issue_queue.sv
`timescale 1ns/1ps

module issue_queue (
  input logic clock,
  input logic reset,
  input logic clear,
  input issue_pkg::instruction_type in0,
  input issue_pkg::instruction_type in1,
  input logic [1:0] issue_count,
  output issue_pkg::instruction_type head0,
  output issue_pkg::instruction_type head1,
  output logic stall
);

  typedef logic [issue_pkg::index_width-1:0] index_t;
  typedef logic [issue_pkg::count_width-1:0] count_t;

  issue_pkg::instruction_type entries [issue_pkg::queue_depth];
  issue_pkg::instruction_type buffer [issue_pkg::queue_depth];

  index_t rid;
  index_t wid;
  count_t count;

  index_t rid_base;
  index_t rid_second;
  index_t wid_write;
  index_t rid_next;
  count_t count_write;
  count_t count_next;

  // write side, new words land behind the stored ones
  always_comb begin
    buffer = entries;
    rid_base = rid;
    wid_write = wid;
    count_write = count;
    if (clear) begin
      rid_base = '0; // flush drops stored and incoming words
      wid_write = '0;
      count_write = '0;
    end else begin
      if (in0.op.valid) begin
        buffer[wid_write] = in0;
        wid_write = wid_write + index_t'(1);
        count_write = count_write + count_t'(1);
      end
      if (in1.op.valid) begin
        buffer[wid_write] = in1;
        wid_write = wid_write + index_t'(1);
        count_write = count_write + count_t'(1);
      end
    end
  end

  assign rid_second = rid_base + index_t'(1);

  // oldest two, same-cycle writes included
  always_comb begin
    head0 = issue_pkg::init_instruction;
    head1 = issue_pkg::init_instruction;
    if (count_write > count_t'(0)) begin
      head0 = buffer[rid_base];
    end
    if (count_write > count_t'(1)) begin
      head1 = buffer[rid_second];
    end
  end

  assign rid_next = rid_base + index_t'(issue_count);
  assign count_next = count_write - count_t'(issue_count);
  assign stall = count_next > count_t'(issue_pkg::stall_level);

  always_ff @(posedge clock) begin
    if (!reset) begin
      rid <= '0;
      wid <= '0;
      count <= '0;
    end else begin
      rid <= rid_next;
      wid <= wid_write;
      count <= count_next;
    end
  end

  always_ff @(posedge clock) begin
    entries <= buffer;
  end

endmodule

//--- source/predecode.sv
`timescale 1ns/1ps

module predecode (
  input logic [31:0] word,
  input logic valid,
  output issue_pkg::instruction_type instr
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [11:0] funct12;
  issue_pkg::op_type op;
  logic known;

  assign opcode = word[6:0];
  assign funct3 = word[14:12];
  assign funct7 = word[31:25];
  assign funct12 = word[31:20];

  always_comb begin
    op = '0;
    known = 1'b1;
    case (opcode)
      issue_pkg::opcode_lui: begin
        op.lui = 1'b1;
        op.wren = 1'b1;
      end
      issue_pkg::opcode_auipc: begin
        op.auipc = 1'b1;
        op.wren = 1'b1;
      end
      issue_pkg::opcode_jal: begin
        op.jal = 1'b1;
        op.wren = 1'b1; // link register
      end
      issue_pkg::opcode_jalr: begin
        op.jalr = 1'b1;
        op.wren = 1'b1;
        op.rden1 = 1'b1;
      end
      issue_pkg::opcode_branch: begin
        op.branch = 1'b1;
        op.rden1 = 1'b1;
        op.rden2 = 1'b1;
      end
      issue_pkg::opcode_load: begin
        op.load = 1'b1;
        op.wren = 1'b1;
        op.rden1 = 1'b1;
      end
      issue_pkg::opcode_store: begin
        op.store = 1'b1;
        op.rden1 = 1'b1;
        op.rden2 = 1'b1;
      end
      issue_pkg::opcode_imm: begin
        op.alu = 1'b1;
        op.wren = 1'b1;
        op.rden1 = 1'b1;
      end
      issue_pkg::opcode_reg: begin
        if (funct7 == 7'b0000001) begin
          op.division = funct3[2]; // m extension split
          op.mult = ~funct3[2];
        end else begin
          op.alu = 1'b1;
        end
        op.wren = 1'b1;
        op.rden1 = 1'b1;
        op.rden2 = 1'b1;
      end
      issue_pkg::opcode_fload: begin
        op.fload = 1'b1;
        op.rden1 = 1'b1; // integer base only
      end
      issue_pkg::opcode_fstore: begin
        op.fstore = 1'b1;
        op.rden1 = 1'b1;
      end
      issue_pkg::opcode_fpu: op.fpu = 1'b1;
      issue_pkg::opcode_fence: op.fence = 1'b1;
      issue_pkg::opcode_system: begin
        if (funct3 == 3'b000) begin
          case (funct12)
            12'h000: op.ecall = 1'b1;
            12'h001: op.ebreak = 1'b1;
            12'h302: op.mret = 1'b1;
            12'h105: op.wfi = 1'b1;
            default: known = 1'b0;
          endcase
        end else if (funct3 == 3'b100) begin
          known = 1'b0;
        end else begin
          op.csreg = 1'b1;
          op.wren = 1'b1;
          op.rden1 = ~funct3[2]; // immediate forms read no register
        end
      end
      default: known = 1'b0;
    endcase
    if (word[11:7] == 5'd0) begin
      op.wren = 1'b0; // x0 is never written
    end
    op.valid = valid & known;
  end

  assign instr = '{
    op: op,
    waddr: word[11:7],
    raddr1: word[19:15],
    raddr2: word[24:20],
    word: word
  };

endmodule

//--- source/issue_pkg.sv
package issue_pkg;

  localparam int queue_depth = 8;
  localparam int index_width = 3;
  localparam int count_width = 4;
  localparam int stall_level = 4; // stall once post-issue count exceeds this

  // rv32 major opcodes
  localparam logic [6:0] opcode_lui = 7'b0110111;
  localparam logic [6:0] opcode_auipc = 7'b0010111;
  localparam logic [6:0] opcode_jal = 7'b1101111;
  localparam logic [6:0] opcode_jalr = 7'b1100111;
  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_load = 7'b0000011;
  localparam logic [6:0] opcode_store = 7'b0100011;
  localparam logic [6:0] opcode_imm = 7'b0010011;
  localparam logic [6:0] opcode_reg = 7'b0110011;
  localparam logic [6:0] opcode_fload = 7'b0000111;
  localparam logic [6:0] opcode_fstore = 7'b0100111;
  localparam logic [6:0] opcode_fpu = 7'b1010011;
  localparam logic [6:0] opcode_fence = 7'b0001111;
  localparam logic [6:0] opcode_system = 7'b1110011;

  typedef struct packed {
    logic valid;
    // basic group
    logic alu;
    logic lui;
    logic auipc;
    logic jal;
    logic jalr;
    logic branch;
    // complex group
    logic load;
    logic store;
    logic mult;
    logic division;
    logic fload;
    logic fstore;
    logic fpu;
    logic csreg;
    logic fence;
    logic ecall;
    logic ebreak;
    logic mret;
    logic wfi;
    // integer register use
    logic wren;
    logic rden1;
    logic rden2;
  } op_type;

  typedef struct packed {
    op_type op;
    logic [4:0] waddr;
    logic [4:0] raddr1;
    logic [4:0] raddr2;
    logic [31:0] word;
  } instruction_type;

  localparam instruction_type init_instruction = '0;

  typedef struct packed {
    logic [31:0] word0;
    logic [31:0] word1;
    logic valid0;
    logic valid1;
  } fetch_pair_type;

  typedef struct packed {
    instruction_type instr0;
    instruction_type instr1;
    logic swap;
  } issue_pair_type;

endpackage
